// ==== psram_subsystem.f ====
+incdir+include
verilog/psram_pkg.sv
verilog/psram_req_slot.sv
verilog/psram_arbiter.sv
verilog/psram_ctrl.sv
verilog/psram_subsystem.sv
bench/hyperram_model.sv
bench/tb_psram_subsystem.sv

// ==== Makefile ====
TOP  := tb_psram_subsystem
SRCS := $(filter-out +%,$(shell cat psram_subsystem.f)) include/psram_defs.svh

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): psram_subsystem.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f psram_subsystem.f

clean:
	rm -rf obj_dir

// ==== bench/psram_stimulus.txt ====
# kind addr wdata byte expected extra; kind 1 cpu write, 2 cpu read, 3 video read,
# 4 cpu and video same cycle, 5 video during cpu read; expected is {addr+2, addr} word
1 000100 1234 0 00000000 0
2 000100 0000 0 00001234 0
1 000102 5678 0 00000000 1
2 000102 0000 0 00005678 1
2 000100 0000 0 00001234 1
1 000100 00ab 1 00000000 0
2 000100 0000 0 000012ab 0
1 000101 cd00 1 00000000 1
2 000100 0000 0 0000cdab 0
3 000100 0000 0 5678cdab 0
3 000100 0000 0 5678cdab 1
1 000104 9abc 0 00000000 0
4 000100 0000 0 5678cdab 0
5 000102 0000 0 9abc5678 1
4 000102 0000 0 9abc5678 1
1 3ffffe beef 0 00000000 0
2 3ffffe 0000 0 0000beef 1
5 000100 0000 0 5678cdab 0

// ==== bench/tb_psram_subsystem.sv ====
// testbench for the psram subsystem replaying a stimulus file against the hyperram model
`include "psram_defs.svh"

module tb_psram_subsystem import psram_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk = 1'b0;
    logic                     resetn = 1'b0;
    logic                     cpu_read = 1'b0;
    logic                     cpu_write = 1'b0;
    logic                     cpu_byte_write = 1'b0;
    logic [`PSRAM_ADDR_W-1:0] cpu_addr = '0;
    logic [15:0]              cpu_din = '0;
    logic [15:0]              cpu_dout;
    logic                     cpu_done;
    logic                     cpu_busy;
    logic                     vid_read = 1'b0;
    logic [`PSRAM_ADDR_W-1:0] vid_addr = '0;
    logic [31:0]              vid_data;
    logic                     vid_done;
    logic                     vid_busy;
    logic                     ready;
    logic                     force_2x = 1'b0;
    logic [15:0]              cfg_value;
    logic                     cs_n;
    logic                     ck_e;
    logic [7:0]               dq_out_ris;
    logic [7:0]               dq_out_fal;
    logic                     dq_oen;
    logic                     rwds_out_ris;
    logic                     rwds_out_fal;
    logic                     rwds_oen;
    logic [7:0]               dq_in_ris;
    logic [7:0]               dq_in_fal;
    logic                     rwds_in_ris;
    logic                     rwds_in_fal;

    logic [3:0]               op_kind [$];   // stimulus columns
    logic [`PSRAM_ADDR_W-1:0] op_addr [$];
    logic [15:0]              op_wdata [$];
    logic                     op_byte [$];
    logic [31:0]              op_exp [$];
    logic                     op_extra [$];
    int                       n_ops = 0;
    int                       cs_falls = 0;   // chip selects before ready

    psram_subsystem i_psram_subsystem (.*);
    hyperram_model  i_model (.*);

    initial begin
        forever #4 clk = ~clk;        // 8 ns
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_rsp(input string name, input psram_rsp_t exp, input psram_rsp_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s expected %h got %h", name, exp, act));
    endtask

    // CR0 value built field by field from the part's register map
    function automatic logic [15:0] cr0_value(input int lat);
        logic [3:0] code;
        case (lat)
            4:       code = 4'b1111;
            5:       code = 4'b0000;
            6:       code = 4'b0001;
            default: code = 4'b1110;   // 3 clocks
        endcase
        // power-down off, default drive, reserved ones, latency, variable 1x/2x,
        // legacy wrapped burst of 16 bytes
        return {1'b1, 3'b000, 4'b1111, code, 1'b0, 1'b1, 2'b10};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                           // inputs move and outputs settle here
    endtask

    task automatic load_stimulus();
        int                       fd;
        string                    line;
        logic [3:0]               k;
        logic [`PSRAM_ADDR_W-1:0] a;
        logic [15:0]              d;
        logic                     b;
        logic [31:0]              e;
        logic                     x;
        fd = $fopen("bench/psram_stimulus.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/psram_stimulus.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h", k, a, d, b, e, x) != 6)
                    abort_run({"malformed stimulus line: ", line});
                op_kind.push_back(k);
                op_addr.push_back(a);
                op_wdata.push_back(d);
                op_byte.push_back(b);
                op_exp.push_back(e);
                op_extra.push_back(x);
            end
        end
        $fclose(fd);
        n_ops = op_kind.size();
    endtask

    // wait for the wanted dones, cpu always ahead of video
    task automatic collect(input logic want_cpu, input logic want_vid, input logic check_cpu,
                           input logic [31:0] exp);
        logic cpu_seen;
        logic vid_seen;
        cpu_seen = !want_cpu;
        vid_seen = !want_vid;
        while (!(cpu_seen && vid_seen)) begin
            next_cycle();
            if (cpu_done) begin
                if (!want_cpu)
                    abort_run("cpu done without a cpu request");
                check_flag("cpu_busy", 1'b0, cpu_busy);   // falls together with done
                if (check_cpu)
                    check_word("cpu_dout", exp[15:0], cpu_dout);
                cpu_seen = 1'b1;
            end
            if (vid_done) begin
                if (!want_vid || !cpu_seen)
                    abort_run("video done out of order or without a video request");
                check_flag("vid_busy", 1'b0, vid_busy);
                check_rsp("vid_data", psram_rsp_t'(exp), psram_rsp_t'(vid_data));
                vid_seen = 1'b1;
            end
        end
    endtask

    // nothing but the config write may touch the memory before ready
    initial begin : startup_monitor
        logic cs_prev;
        cs_prev = 1'b1;
        wait (resetn);
        while (!ready) begin
            if (cpu_done || vid_done)
                abort_run("client done seen before ready");
            if (cs_prev && !cs_n)
                cs_falls++;
            cs_prev = cs_n;
            next_cycle();
        end
    end

    initial begin : watchdog
        int limit;
        wait (n_ops > 0);
        limit = (n_ops + 1) * 40 + `PSRAM_INIT_CYCLES + 40;   // one more for the early read
        repeat (limit) @(posedge clk);
        $display("timeout: the operations did not complete in %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int cycles;
        void'($urandom(32'h8f850777));
        load_stimulus();
        repeat (10) @(posedge clk);
        #1;
        check_flag("ready", 1'b0, ready);
        check_flag("cs_n", 1'b1, cs_n);
        check_flag("ck_e", 1'b0, ck_e);
        check_flag("dq_oen", 1'b1, dq_oen);
        check_flag("rwds_oen", 1'b1, rwds_oen);
        check_flag("cpu_done", 1'b0, cpu_done);
        check_flag("vid_done", 1'b0, vid_done);
        check_flag("cpu_busy", 1'b0, cpu_busy);
        check_flag("vid_busy", 1'b0, vid_busy);
        resetn   = 1'b1;
        cpu_read = 1'b1;              // early read, held back until the config write is over
        next_cycle();
        cpu_read = 1'b0;
        check_flag("cpu_busy", 1'b1, cpu_busy);
        cycles = 1;
        while (!ready && cycles < 200) begin
            next_cycle();
            cycles++;
        end
        if (cycles != `PSRAM_INIT_CYCLES + 6)
            abort_run($sformatf("ready rose after %0d cycles instead of %0d", cycles,
                                `PSRAM_INIT_CYCLES + 6));
        if (cs_falls != 1)
            abort_run("chip select went low other than for the config write before ready");
        check_word("cfg_value", cr0_value(`PSRAM_LATENCY), cfg_value);
        collect(1'b1, 1'b0, 1'b0, 32'h0);   // early read completes only after ready

        // kinds: 1 cpu write, 2 cpu read, 3 video, 4 same cycle, 5 video during cpu
        for (int i = 0; i < n_ops; i++) begin
            repeat ($urandom % 4) next_cycle();
            force_2x       = op_extra[i];
            cpu_addr       = op_addr[i];
            vid_addr       = op_addr[i];
            cpu_din        = op_wdata[i];
            cpu_byte_write = op_byte[i];
            cpu_write      = (op_kind[i] == 1);
            cpu_read       = (op_kind[i] == 2 || op_kind[i] >= 4);
            vid_read       = (op_kind[i] == 3 || op_kind[i] == 4);
            next_cycle();
            cpu_read       = 1'b0;
            cpu_write      = 1'b0;
            cpu_byte_write = 1'b0;
            vid_read       = 1'b0;
            if (op_kind[i] != 3)
                check_flag("cpu_busy", 1'b1, cpu_busy);
            if (op_kind[i] == 3 || op_kind[i] == 4)
                check_flag("vid_busy", 1'b1, vid_busy);
            if (op_kind[i] == 2) begin
                cpu_addr = op_addr[i] ^ 22'h40;    // second pulse while busy, dropped
                cpu_read = 1'b1;
                next_cycle();
                cpu_read = 1'b0;
            end
            if (op_kind[i] == 5) begin
                repeat (2) next_cycle();
                vid_read = 1'b1;                   // lands mid cpu access
                next_cycle();
                vid_read = 1'b0;
                check_flag("vid_busy", 1'b1, vid_busy);
            end
            collect(op_kind[i] != 3, op_kind[i] >= 3, op_kind[i] != 1, op_exp[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== bench/hyperram_model.sv ====
// hyperram behavioural model on byte lanes, 1x/2x latency, masked writes, CR0 record
`include "psram_defs.svh"

module hyperram_model (
    input  logic        clk,
    input  logic        force_2x,     // ask for double latency during CA
    input  logic        cs_n,
    input  logic [7:0]  dq_out_ris,
    input  logic [7:0]  dq_out_fal,
    input  logic        dq_oen,
    input  logic        rwds_out_ris,
    input  logic        rwds_out_fal,
    input  logic        rwds_oen,
    output logic [7:0]  dq_in_ris,
    output logic [7:0]  dq_in_fal,
    output logic        rwds_in_ris,
    output logic        rwds_in_fal,
    output logic [15:0] cfg_value     // last CR0 write
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [int];           // word addressed, sparse
    logic [47:0] ca = '0;
    logic [15:0] rd_word = '0;
    logic [15:0] cfg_q = '0;
    logic        strobe_q = 1'b0;
    int          pair_cnt = 0;        // CA byte pairs seen
    int          cyc = 0;             // clocks since cs_n fell
    int          waddr;
    int          rd_start;
    int          wr_cyc;
    logic        ca_phase;

    // untouched words read back a pattern built from the whole address
    function automatic logic [15:0] fill_word(input int a);
        return 16'(a) ^ 16'(a >>> 16) ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] read_word(input int a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    assign waddr     = {11'b0, ca[33:16], ca[2:0]};   // row bits and lower column
    // first read word 4 clocks past the latency count
    assign rd_start  = force_2x ? 7 + 2 * `PSRAM_LATENCY : 7 + `PSRAM_LATENCY;
    // write word only taken 2 clocks past the latency count
    assign wr_cyc    = force_2x ? 2 + 2 * `PSRAM_LATENCY : 2 + `PSRAM_LATENCY;
    assign ca_phase  = !cs_n && !dq_oen && pair_cnt < 3;
    assign rwds_in_ris = ca_phase ? force_2x : strobe_q;  // high in CA = 2x
    assign rwds_in_fal = ca_phase && force_2x;            // low half of the strobe
    assign dq_in_ris = rd_word[15:8];
    assign dq_in_fal = rd_word[7:0];
    assign cfg_value = cfg_q;

    always @(posedge clk) begin : lanes
        logic [15:0] old_word;
        old_word = read_word(waddr);
        strobe_q <= 1'b0;
        if (cs_n !== 1'b0) begin
            pair_cnt <= 0;
            cyc      <= 0;
        end else begin
            cyc <= cyc + 1;
            if (!dq_oen && pair_cnt < 3) begin
                ca       <= {ca[31:0], dq_out_ris, dq_out_fal};
                pair_cnt <= pair_cnt + 1;
            end else if (!dq_oen && pair_cnt == 3 && ca[46]) begin
                cfg_q    <= {dq_out_ris, dq_out_fal};  // register space, zero latency
                pair_cnt <= 4;
            end
            // write word, rwds high keeps that byte
            if (pair_cnt == 3 && !ca[47] && !ca[46] && !rwds_oen && cyc == wr_cyc)
                mem[waddr] = {rwds_out_ris ? old_word[15:8] : dq_out_ris,
                              rwds_out_fal ? old_word[7:0] : dq_out_fal};
            // read: two words back to back, one strobe edge each
            if (pair_cnt == 3 && ca[47] && (cyc + 1 == rd_start || cyc + 1 == rd_start + 1)) begin
                rd_word  <= read_word(waddr + cyc + 1 - rd_start);
                strobe_q <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/psram_subsystem.sv ====
// psram subsystem top joining cpu and video request slots, the arbiter and the controller
`include "psram_defs.svh"

module psram_subsystem import psram_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    // cpu port
    input  logic                     cpu_read,
    input  logic                     cpu_write,
    input  logic                     cpu_byte_write,
    input  logic [`PSRAM_ADDR_W-1:0] cpu_addr,
    input  logic [15:0]              cpu_din,
    output logic [15:0]              cpu_dout,
    output logic                     cpu_done,
    output logic                     cpu_busy,
    // video port, 32-bit reads
    input  logic                     vid_read,
    input  logic [`PSRAM_ADDR_W-1:0] vid_addr,
    output logic [31:0]              vid_data,
    output logic                     vid_done,
    output logic                     vid_busy,
    output logic                     ready,
    // byte lanes to the memory
    output logic                     cs_n,
    output logic                     ck_e,
    output logic [7:0]               dq_out_ris,
    output logic [7:0]               dq_out_fal,
    output logic                     dq_oen,
    output logic                     rwds_out_ris,
    output logic                     rwds_out_fal,
    output logic                     rwds_oen,
    input  logic [7:0]               dq_in_ris,
    input  logic [7:0]               dq_in_fal,
    input  logic                     rwds_in_ris,
    input  logic                     rwds_in_fal
);

    localparam int N = `PSRAM_NUM_CLIENTS;

    logic [N-1:0]              c_read;
    logic [N-1:0]              c_write;
    logic [N-1:0]              c_byte;
    logic [N-1:0]              c_two;
    logic [`PSRAM_ADDR_W-1:0] c_addr [N];
    logic [15:0]              c_wdata [N];
    logic [N-1:0]              c_busy;
    logic [N-1:0]              c_done;
    psram_rsp_t               c_rsp [N];

    slot_if slot_bus [N] ();
    mem_if  mem_bus ();

    // slot 0 cpu, slot 1 video; video only reads, always two words
    assign c_read     = {vid_read, cpu_read};
    assign c_write    = {1'b0, cpu_write};
    assign c_byte     = {1'b0, cpu_byte_write};
    assign c_two      = {vid_read, 1'b0};
    assign c_addr[0]  = cpu_addr;
    assign c_addr[1]  = vid_addr;
    assign c_wdata[0] = cpu_din;
    assign c_wdata[1] = '0;

    assign cpu_dout = c_rsp[0].rdata_lo;
    assign cpu_done = c_done[0];
    assign cpu_busy = c_busy[0];
    assign vid_data = c_rsp[1];          // {addr+2, addr}
    assign vid_done = c_done[1];
    assign vid_busy = c_busy[1];

    for (genvar i = 0; i < N; i++) begin : g_slot
        psram_req_slot i_slot (
            .clk        (clk),
            .resetn     (resetn),
            .read       (c_read[i]),
            .write      (c_write[i]),
            .byte_write (c_byte[i]),
            .two_word   (c_two[i]),
            .addr       (c_addr[i]),
            .wdata      (c_wdata[i]),
            .busy       (c_busy[i]),
            .done       (c_done[i]),
            .rsp        (c_rsp[i]),
            .slot       (slot_bus[i])
        );
    end

    psram_arbiter i_arbiter (
        .clk    (clk),
        .resetn (resetn),
        .slots  (slot_bus),
        .mem    (mem_bus)
    );

    psram_ctrl i_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .ready        (ready),
        .mem          (mem_bus),
        .cs_n         (cs_n),
        .ck_e         (ck_e),
        .dq_out_ris   (dq_out_ris),
        .dq_out_fal   (dq_out_fal),
        .dq_oen       (dq_oen),
        .rwds_out_ris (rwds_out_ris),
        .rwds_out_fal (rwds_out_fal),
        .rwds_oen     (rwds_oen),
        .dq_in_ris    (dq_in_ris),
        .dq_in_fal    (dq_in_fal),
        .rwds_in_ris  (rwds_in_ris),
        .rwds_in_fal  (rwds_in_fal)
    );

endmodule

// ==== verilog/psram_ctrl.sv ====
// hyperram controller doing power-up wait, config write and single/two word accesses
`include "psram_defs.svh"

module psram_ctrl import psram_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    output logic       ready,        // config written
    mem_if.slave       mem,
    output logic       cs_n,
    output logic       ck_e,         // clock enable towards the pin
    output logic [7:0] dq_out_ris,
    output logic [7:0] dq_out_fal,
    output logic       dq_oen,       // 1 = released
    output logic       rwds_out_ris,
    output logic       rwds_out_fal,
    output logic       rwds_oen,
    input  logic [7:0] dq_in_ris,
    input  logic [7:0] dq_in_fal,
    input  logic       rwds_in_ris,
    input  logic       rwds_in_fal
);

    localparam int LAT   = `PSRAM_LATENCY;
    localparam int CNT_W = $clog2(`PSRAM_INIT_CYCLES + 1);

    // CR0 latency field
    localparam logic [3:0] LAT_CODE = (LAT == 4) ? 4'b1111 :
                                      (LAT == 5) ? 4'b0000 :
                                      (LAT == 6) ? 4'b0001 : 4'b1110;
    // low nibble 6: variable 1x/2x latency, default burst
    localparam logic [15:0] CFG_VALUE = {8'h8f, LAT_CODE, 4'h6};

    typedef enum logic [2:0] {
        INIT_ST,
        CONFIG_ST,
        IDLE_ST,
        READ_ST,
        WRITE_ST
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] init_cnt;
    logic [15:0]      cycles_sr;  // one-hot, bit n = cycle n of the phase
    logic [63:0]      dq_sr;      // top 16 bits are on the lanes
    psram_req_t       req_q;
    psram_rsp_t       rsp_q;
    logic             extra_lat;  // memory asked for 2x
    logic             wait_rd;
    logic             wait_rd2;
    logic             done_q;
    logic             strobe;
    logic             write_now;

    assign strobe    = rwds_in_ris ^ rwds_in_fal;   // rwds edge, word on the lanes
    assign write_now = (cycles_sr[2+LAT] && !extra_lat) || (cycles_sr[2+2*LAT] && extra_lat);

    assign ready      = (state != INIT_ST) && (state != CONFIG_ST);
    assign mem.accept = ready && (state == IDLE_ST) && cs_n; // cs_n high between accesses
    assign mem.done   = done_q;
    assign mem.rsp    = rsp_q;
    assign dq_out_ris = dq_sr[63:56];
    assign dq_out_fal = dq_sr[55:48];

    always_ff @(posedge clk) begin
        cycles_sr <= {cycles_sr[14:0], 1'b0};
        dq_sr     <= {dq_sr[47:0], 16'h0};     // one byte pair per cycle
        done_q    <= 1'b0;

        case (state)
            INIT_ST: begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == CNT_W'(`PSRAM_INIT_CYCLES)) begin
                    cs_n      <= 1'b0;
                    cycles_sr <= 16'b1;
                    state     <= CONFIG_ST;
                end
            end

            CONFIG_ST: begin
                if (cycles_sr[0]) begin
                    // register write to CR0, no latency and no rwds
                    dq_sr  <= {8'h60, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, CFG_VALUE};
                    dq_oen <= 1'b0;
                    ck_e   <= 1'b1;
                end
                if (cycles_sr[4]) begin
                    cs_n   <= 1'b1;
                    ck_e   <= 1'b0;
                    dq_oen <= 1'b1;
                    state  <= IDLE_ST;
                end
            end

            IDLE_ST: begin
                cs_n     <= 1'b1;
                ck_e     <= 1'b0;
                dq_oen   <= 1'b1;
                rwds_oen <= 1'b1;
                if (mem.valid && mem.accept) begin
                    req_q <= mem.req;
                    // CA: r/w, memory space, row/upper column, lower column
                    dq_sr <= {~mem.req.write, 31'(mem.req.addr[`PSRAM_ADDR_W-1:4]),
                              13'b0, mem.req.addr[3:1], 16'h0};
                    cs_n      <= 1'b0;
                    ck_e      <= 1'b1;
                    dq_oen    <= 1'b0;
                    wait_rd   <= 1'b0;
                    wait_rd2  <= 1'b0;
                    cycles_sr <= 16'b10;          // CA goes out in cycles 1..3
                    state     <= mem.req.write ? WRITE_ST : READ_ST;
                end
            end

            READ_ST: begin
                if (cycles_sr[3])
                    dq_oen <= 1'b1;               // CA sent, hand the bus over
                if (cycles_sr[9])
                    wait_rd <= 1'b1;              // strobe trusted from cycle 10 on
                if ((wait_rd || wait_rd2) && strobe) begin
                    if (wait_rd)
                        rsp_q.rdata_lo <= {dq_in_ris, dq_in_fal};
                    else
                        rsp_q.rdata_hi <= {dq_in_ris, dq_in_fal};
                    wait_rd  <= 1'b0;
                    wait_rd2 <= wait_rd && req_q.two_word;   // video wants one more
                    if (wait_rd2 || !req_q.two_word) begin
                        cs_n   <= 1'b1;
                        ck_e   <= 1'b0;
                        done_q <= 1'b1;
                        state  <= IDLE_ST;
                    end
                end
            end

            WRITE_ST: begin
                if (cycles_sr[3])
                    extra_lat <= rwds_in_ris | rwds_in_fal; // rwds high in CA = 2x
                if (write_now) begin
                    rwds_oen     <= 1'b0;
                    // rwds high masks a byte, addr[0] set writes the upper one
                    rwds_out_ris <= req_q.byte_write && !req_q.addr[0];
                    rwds_out_fal <= req_q.byte_write && req_q.addr[0];
                    dq_sr[63:48] <= req_q.wdata;
                    done_q       <= 1'b1;          // seen while the word is on the lanes
                    state        <= IDLE_ST;       // idle closes cs_n a cycle later
                end
            end

            default: state <= INIT_ST;
        endcase

        if (!resetn) begin
            state     <= INIT_ST;
            init_cnt  <= '0;
            cycles_sr <= '0;
            cs_n      <= 1'b1;
            ck_e      <= 1'b0;
            dq_oen    <= 1'b1;
            rwds_oen  <= 1'b1;
            wait_rd   <= 1'b0;
            wait_rd2  <= 1'b0;
            done_q    <= 1'b0;
        end
    end

endmodule

// ==== verilog/psram_arbiter.sv ====
// fixed-priority arbiter: grants one pending slot, forwards it and routes completion back
`include "psram_defs.svh"

module psram_arbiter import psram_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    slot_if.arb_side slots [`PSRAM_NUM_CLIENTS],
    mem_if.master    mem
);

    localparam int N = `PSRAM_NUM_CLIENTS;

    logic [N-1:0] pend;
    logic [N-1:0] grant_q;
    psram_req_t   reqs [N];
    logic         active;   // an access is owned until mem.done
    logic         valid_q;
    client_idx_t  owner;
    client_idx_t  pick;

    // flatten the slot array, interface arrays only take constant indices
    for (genvar i = 0; i < N; i++) begin : g_slot
        assign pend[i]        = slots[i].pending;
        assign reqs[i]        = slots[i].req;
        assign slots[i].grant = grant_q[i];
        assign slots[i].done  = mem.done && (owner == client_idx_t'(i)); // owner only
        assign slots[i].rsp   = (owner == client_idx_t'(i)) ? mem.rsp : '0;
    end

    // lowest pending index wins
    always_comb begin
        pick = '0;
        for (int k = N - 1; k >= 0; k--) begin
            if (pend[k])
                pick = client_idx_t'(k);
        end
    end

    assign mem.valid = valid_q;
    assign mem.req   = reqs[owner];     // slot holds it stable while busy

    always_ff @(posedge clk) begin
        grant_q <= '0;                  // pulse

        if (!active && |pend) begin
            active        <= 1'b1;
            owner         <= pick;
            grant_q[pick] <= 1'b1;
            valid_q       <= 1'b1;
        end

        if (valid_q && mem.accept)
            valid_q <= 1'b0;            // taken, hold off until done

        if (active && mem.done)
            active <= 1'b0;             // free for the next grant

        if (!resetn) begin
            active  <= 1'b0;
            valid_q <= 1'b0;
            grant_q <= '0;
            owner   <= '0;
        end
    end

endmodule

// ==== verilog/psram_req_slot.sv ====
// request slot holding one client's access until granted, then handing back the result
`include "psram_defs.svh"

module psram_req_slot import psram_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     read,       // single cycle request pulses
    input  logic                     write,
    input  logic                     byte_write,
    input  logic                     two_word,
    input  logic [`PSRAM_ADDR_W-1:0] addr,
    input  logic [15:0]              wdata,
    output logic                     busy,       // request pulse to done
    output logic                     done,
    output psram_rsp_t               rsp,
    slot_if.slot_side                slot
);

    logic       pending_q;
    psram_req_t req_q;

    assign slot.pending = pending_q;
    assign slot.req     = req_q;

    always_ff @(posedge clk) begin
        done <= 1'b0;

        // a pulse while already busy is dropped
        if ((read || write) && !busy) begin
            req_q     <= '{write: write, byte_write: byte_write, two_word: two_word,
                           addr: addr, wdata: wdata};
            pending_q <= 1'b1;
            busy      <= 1'b1;
        end

        if (slot.grant)
            pending_q <= 1'b0;          // arbiter owns it now

        if (slot.done) begin
            rsp  <= slot.rsp;           // held until the next read
            done <= 1'b1;
            busy <= 1'b0;               // falls together with done
        end

        if (!resetn) begin
            pending_q <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end
    end

endmodule

// ==== verilog/psram_pkg.sv ====
// psram shared request/response types plus the slot and memory-side interfaces
`include "psram_defs.svh"

package psram_pkg;

    typedef struct packed {
        logic                     write;      // 1 = write, 0 = read
        logic                     byte_write; // addr[0] picks the byte
        logic                     two_word;   // video read of addr and addr+2
        logic [`PSRAM_ADDR_W-1:0] addr;
        logic [15:0]              wdata;
    } psram_req_t;

    typedef struct packed {
        logic [15:0] rdata_hi; // second word, two_word only
        logic [15:0] rdata_lo; // first word
    } psram_rsp_t;

    typedef logic [$clog2(`PSRAM_NUM_CLIENTS > 1 ? `PSRAM_NUM_CLIENTS : 2)-1:0] client_idx_t;

endpackage

// one client slot towards the arbiter
interface slot_if import psram_pkg::*; ();
    logic       pending;
    psram_req_t req;
    logic       grant;   // single cycle, only while pending
    logic       done;    // single cycle, after the access
    psram_rsp_t rsp;

    modport slot_side (output pending, output req, input grant, input done, input rsp);
    modport arb_side  (input pending, input req, output grant, output done, output rsp);
endinterface

// arbiter to controller, one access in flight
interface mem_if import psram_pkg::*; ();
    logic       valid;
    psram_req_t req;
    logic       accept;  // idle and ready
    logic       done;    // once per accepted request
    psram_rsp_t rsp;

    modport master (output valid, output req, input accept, input done, input rsp);
    modport slave  (input valid, input req, output accept, output done, output rsp);
endinterface

// ==== include/psram_defs.svh ====
// psram subsystem build constants for latency, power-up delay, address width and clients
`ifndef PSRAM_DEFS_SVH
`define PSRAM_DEFS_SVH

// initial access latency in clocks, 3 to 6
`define PSRAM_LATENCY 3

// clocks from reset release to the configuration write, kept short for simulation
`define PSRAM_INIT_CYCLES 20

// byte address width, 4MB die
`define PSRAM_ADDR_W 22

// request slots: 0 is the cpu, 1 is video; lower index wins
`define PSRAM_NUM_CLIENTS 2

`endif
